/* include/isa_params.svh */
//############################
// ISA constants for the 16-bit
// execute slice
//############################
`ifndef ISA_PARAMS_SVH
`define ISA_PARAMS_SVH

// Data and instruction word width
`define WORD_W 16
// Register file size
`define NUM_REGS 8
// JAL and JALR link target
`define LINK_REG 3'd7

// Immediate group
`define OP_ADDI 5'b01000
`define OP_SUBI 5'b01001
`define OP_XORI 5'b01010
`define OP_ANDNI 5'b01011
// Load byte immediate
`define OP_LBI 5'b11000
// Register ALU group, function field picks the operation
`define OP_ALUR 5'b11011
// Branches on rs
`define OP_BEQZ 5'b01100
`define OP_BNEZ 5'b01101
`define OP_BLTZ 5'b01110
`define OP_BGEZ 5'b01111
// Jumps
`define OP_J 5'b00100
`define OP_JR 5'b00101
`define OP_JAL 5'b00110
`define OP_JALR 5'b00111
`define OP_NOP 5'b00001

// Function field of the register group
`define FN_ADD 2'b00
`define FN_SUB 2'b01
`define FN_XOR 2'b10
`define FN_ANDN 2'b11

`endif

/* design/isaPkg.sv */
//############################
// Shared types of the execute
// slice
//############################
`default_nettype none

package isaPkg;

	// Register format: opcode, rs, rt, rd, function
	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] funct;
	} regViewT;

	// Immediate format: opcode, rs, rd, 5-bit immediate
	// imm8 and imm11 are just the low bits of the same word
	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} immViewT;

	// One instruction word, two decodings
	typedef union packed {
		regViewT r;
		immViewT i;
	} instrWordT;

	// Immediate extension choice
	typedef enum logic [2:0] {
		IMM_ZE5 = 3'b000,
		IMM_ZE8 = 3'b001,
		IMM_SE5 = 3'b010,
		IMM_SE8 = 3'b100,
		IMM_SE11 = 3'b110
	} immSelT;

	// ALU operation, applied after the operand inversions
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_XOR = 2'b01,
		ALU_ANDN = 2'b10,
		ALU_PASSA = 2'b11
	} aluOpT;

endpackage

`default_nettype wire

/* design/instrDecode.sv */
//############################
// Instruction decoder
// Opcode and function to control levels
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module instrDecode (
	input wire isaPkg::instrWordT instr,
	input wire instrValid,
	output isaPkg::immSelT immSel,
	output logic aluSrcReg,
	output logic invA,
	output logic invB,
	output logic cin,
	output isaPkg::aluOpT aluOp,
	output logic [2:0] dest,
	output logic regWrite,
	output logic linkWrite,
	output logic isBranch,
	output logic isJump,
	output logic isJumpReg
);
	import isaPkg::*;

	// Write enable before the valid gate
	logic writeEn;

	always_comb begin
		// Defaults describe an instruction that changes nothing
		immSel = IMM_SE5;
		aluSrcReg = 1'b0;
		invA = 1'b0;
		invB = 1'b0;
		cin = 1'b0;
		aluOp = ALU_ADD;
		dest = instr.i.rd;
		writeEn = 1'b0;
		linkWrite = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isJumpReg = 1'b0;
		case (instr.r.opcode)
			`OP_ALUR: begin
				aluSrcReg = 1'b1;
				dest = instr.r.rd;
				writeEn = 1'b1;
				case (instr.r.funct)
					`FN_ADD: aluOp = ALU_ADD;
					// rt - rs as B + ~A + 1
					`FN_SUB: begin
						invA = 1'b1;
						cin = 1'b1;
					end
					`FN_XOR: aluOp = ALU_XOR;
					// A & ~B
					default: begin
						invB = 1'b1;
						aluOp = ALU_ANDN;
					end
				endcase
			end
			`OP_ADDI: begin
				writeEn = 1'b1;
			end
			`OP_SUBI: begin
				invA = 1'b1;
				cin = 1'b1;
				writeEn = 1'b1;
			end
			// Logic immediates are zero extended
			`OP_XORI: begin
				immSel = IMM_ZE5;
				aluOp = ALU_XOR;
				writeEn = 1'b1;
			end
			`OP_ANDNI: begin
				immSel = IMM_ZE5;
				invB = 1'b1;
				aluOp = ALU_ANDN;
				writeEn = 1'b1;
			end
			// LBI writes its rs field
			`OP_LBI: begin
				immSel = IMM_SE8;
				aluOp = ALU_PASSA;
				dest = instr.r.rs;
				writeEn = 1'b1;
			end
			`OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ: begin
				immSel = IMM_SE8;
				isBranch = 1'b1;
			end
			`OP_J: begin
				immSel = IMM_SE11;
				isJump = 1'b1;
			end
			`OP_JAL: begin
				immSel = IMM_SE11;
				isJump = 1'b1;
				linkWrite = 1'b1;
				dest = `LINK_REG;
				writeEn = 1'b1;
			end
			`OP_JR: begin
				isJumpReg = 1'b1;
				immSel = IMM_SE8;
			end
			`OP_JALR: begin
				isJumpReg = 1'b1;
				immSel = IMM_SE8;
				linkWrite = 1'b1;
				dest = `LINK_REG;
				writeEn = 1'b1;
			end
			// NOP and unused opcodes keep the defaults
			default: begin
				writeEn = 1'b0;
			end
		endcase
	end

	// No register write without an issued instruction
	assign regWrite = writeEn & instrValid;

	// Next-PC sources are exclusive for an issued instruction
	always_comb begin
		assert (!instrValid || $onehot0({isBranch, isJump, isJumpReg}))
			else $error("instrDecode: more than one PC source selected");
	end

endmodule

`default_nettype wire

/* design/executeInstruction.sv */
//############################
// Execute block: ALU, immediate
// extension and next PC
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module executeInstruction (
	input wire isaPkg::instrWordT instr,
	input wire [`WORD_W-1:0] regA,
	input wire [`WORD_W-1:0] regB,
	input wire [`WORD_W-1:0] pc,
	input wire isaPkg::immSelT immSel,
	input wire aluSrcReg,
	input wire invA,
	input wire invB,
	input wire cin,
	input wire isaPkg::aluOpT aluOp,
	input wire isBranch,
	input wire isJump,
	input wire isJumpReg,
	output logic [`WORD_W-1:0] aluOut,
	output logic [`WORD_W-1:0] updatedPc
);
	import isaPkg::*;

	// Extended immediates straight from the word
	logic [`WORD_W-1:0] zeroExt5, zeroExt8;
	logic [`WORD_W-1:0] signExt5, signExt8, signExt11;
	// Immediate picked by immSel
	logic [`WORD_W-1:0] extImm;
	// ALU operands before and after inversion
	logic [`WORD_W-1:0] srcA, srcB, opA, opB;
	// Branch decision and PC pieces
	logic branchTaken;
	logic [`WORD_W-1:0] pcPlus2, pcOffset;

	assign zeroExt5 = {11'b0, instr[4:0]};
	assign zeroExt8 = {8'b0, instr[7:0]};
	assign signExt5 = {{11{instr[4]}}, instr[4:0]};
	assign signExt8 = {{8{instr[7]}}, instr[7:0]};
	assign signExt11 = {{5{instr[10]}}, instr[10:0]};

	always_comb begin
		case (immSel)
			IMM_ZE5: extImm = zeroExt5;
			IMM_ZE8: extImm = zeroExt8;
			IMM_SE5: extImm = signExt5;
			IMM_SE8: extImm = signExt8;
			default: extImm = signExt11;
		endcase
	end

	// LBI carries its immediate through the A path
	assign srcA = (aluOp == ALU_PASSA) ? extImm : regA;
	// Second operand is rt or the immediate
	assign srcB = aluSrcReg ? regB : extImm;
	assign opA = srcA ^ {`WORD_W{invA}};
	assign opB = srcB ^ {`WORD_W{invB}};

	always_comb begin
		case (aluOp)
			ALU_ADD: aluOut = opA + opB + {{(`WORD_W-1){1'b0}}, cin};
			ALU_XOR: aluOut = opA ^ opB;
			// B already inverted by invB
			ALU_ANDN: aluOut = opA & opB;
			default: aluOut = opA;
		endcase
	end

	// Branches look at rs itself, not the ALU result
	always_comb begin
		case (instr.r.opcode)
			`OP_BEQZ: branchTaken = (regA == '0);
			`OP_BNEZ: branchTaken = (regA != '0);
			`OP_BLTZ: branchTaken = regA[`WORD_W-1];
			`OP_BGEZ: branchTaken = ~regA[`WORD_W-1];
			default: branchTaken = 1'b0;
		endcase
	end

	assign pcPlus2 = pc + `WORD_W'd2;

	// Offset added to PC+2: imm11 for jumps, imm8 for a taken branch
	always_comb begin
		if (isJump) begin
			pcOffset = signExt11;
		end else if (isBranch && branchTaken) begin
			pcOffset = signExt8;
		end else begin
			pcOffset = '0;
		end
	end

	// Register jumps are relative to rs, everything else to PC+2
	assign updatedPc = isJumpReg ? (regA + signExt8) : (pcPlus2 + pcOffset);

endmodule

`default_nettype wire

/* design/resultWriteback.sv */
//############################
// Register file and registered
// writeback report
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module resultWriteback (
	input wire clk,
	input wire rstN,
	input wire instrValid,
	input wire [2:0] rs,
	input wire [2:0] rt,
	input wire [2:0] dest,
	input wire regWrite,
	input wire linkWrite,
	input wire [`WORD_W-1:0] aluOut,
	input wire [`WORD_W-1:0] pc,
	input wire [`WORD_W-1:0] updatedPc,
	output logic [`WORD_W-1:0] regA,
	output logic [`WORD_W-1:0] regB,
	output logic wbValid,
	output logic wbWrite,
	output logic [2:0] wbReg,
	output logic [`WORD_W-1:0] wbData,
	output logic [`WORD_W-1:0] pcNext
);

	logic [`WORD_W-1:0] regs [`NUM_REGS];
	// Value headed for dest this cycle
	logic [`WORD_W-1:0] writeValue;

	// Two asynchronous read ports
	assign regA = regs[rs];
	assign regB = regs[rt];

	// Links store the return address
	assign writeValue = linkWrite ? (pc + `WORD_W'd2) : aluOut;

	// Write lands on the same edge the report registers,
	// so a back-to-back reader sees it
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[dest] <= writeValue;
		end
	end

	// Control part of the report
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			wbWrite <= 1'b0;
			pcNext <= '0;
		end else begin
			wbValid <= instrValid;
			wbWrite <= regWrite;
			if (instrValid) begin
				pcNext <= updatedPc;
			end
		end
	end

	// Payload holds its value between instructions
	always_ff @(posedge clk) begin
		if (instrValid) begin
			wbReg <= dest;
			wbData <= writeValue;
		end
	end

	// A reported write always belongs to a reported instruction
	wbWriteHasValid: assert property (@(posedge clk) disable iff (!rstN)
		wbWrite |-> wbValid);

	// Decode routes every link write to the link register
	linkToR7: assert property (@(posedge clk) disable iff (!rstN)
		(instrValid && linkWrite) |=> (wbWrite && wbReg == `LINK_REG));

endmodule

`default_nettype wire

/* design/cpuCore.sv */
//############################
// Execute slice top level
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module cpuCore (
	input wire clk,
	input wire rstN,
	input wire instrValid,
	input wire [`WORD_W-1:0] instr,
	input wire [`WORD_W-1:0] pc,
	output logic wbValid,
	output logic wbWrite,
	output logic [2:0] wbReg,
	output logic [`WORD_W-1:0] wbData,
	output logic [`WORD_W-1:0] pcNext
);
	import isaPkg::*;

	// Instruction seen through its field views
	instrWordT instrWord;
	// Register read data
	logic [`WORD_W-1:0] regA, regB;
	// Decode controls
	immSelT immSel;
	aluOpT aluOp;
	logic aluSrcReg, invA, invB, cin;
	logic [2:0] dest;
	logic regWrite, linkWrite;
	logic isBranch, isJump, isJumpReg;
	// Execute results
	logic [`WORD_W-1:0] aluOut, updatedPc;

	assign instrWord = instr;

	instrDecode decode (
		.instr(instrWord), .instrValid(instrValid),
		.immSel(immSel), .aluSrcReg(aluSrcReg),
		.invA(invA), .invB(invB), .cin(cin), .aluOp(aluOp),
		.dest(dest), .regWrite(regWrite), .linkWrite(linkWrite),
		.isBranch(isBranch), .isJump(isJump), .isJumpReg(isJumpReg)
	);

	executeInstruction execute (
		.instr(instrWord), .regA(regA), .regB(regB), .pc(pc),
		.immSel(immSel), .aluSrcReg(aluSrcReg),
		.invA(invA), .invB(invB), .cin(cin), .aluOp(aluOp),
		.isBranch(isBranch), .isJump(isJump), .isJumpReg(isJumpReg),
		.aluOut(aluOut), .updatedPc(updatedPc)
	);

	// rt read port uses the register view, rs is shared by both views
	resultWriteback writeback (
		.clk(clk), .rstN(rstN), .instrValid(instrValid),
		.rs(instrWord.r.rs), .rt(instrWord.r.rt), .dest(dest),
		.regWrite(regWrite), .linkWrite(linkWrite),
		.aluOut(aluOut), .pc(pc), .updatedPc(updatedPc),
		.regA(regA), .regB(regB),
		.wbValid(wbValid), .wbWrite(wbWrite), .wbReg(wbReg),
		.wbData(wbData), .pcNext(pcNext)
	);

endmodule

`default_nettype wire

/* test/tbClock.sv */
//############################
// Testbench clock and reset
//############################
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic rstN
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Low for 16 rising edges, released just after the last one
	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* test/tbChecker.sv */
//############################
// Writeback checker
// Compares each report with the model queue
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module tbChecker (
	input wire clk,
	input wire rstN,
	input wire wbValid,
	input wire wbWrite,
	input wire [2:0] wbReg,
	input wire [`WORD_W-1:0] wbData,
	input wire [`WORD_W-1:0] pcNext
);

	// Expected reports, oldest first
	logic expWrite [$];
	logic [2:0] expReg [$];
	logic [`WORD_W-1:0] expData [$];
	logic [`WORD_W-1:0] expPc [$];

	int checkCount = 0;
	int errorCount = 0;
	// Counts at the end of the previous test
	int lastChecks = 0;
	int lastErrors = 0;

	task automatic pushExpected(input logic write, input logic [2:0] dst,
			input logic [`WORD_W-1:0] data, input logic [`WORD_W-1:0] nextPc);
		expWrite.push_back(write);
		expReg.push_back(dst);
		expData.push_back(data);
		expPc.push_back(nextPc);
	endtask

	function automatic int pending();
		return expPc.size();
	endfunction

	function automatic int checks();
		return checkCount;
	endfunction

	function automatic int errors();
		return errorCount;
	endfunction

	task automatic clearPending();
		expWrite.delete();
		expReg.delete();
		expData.delete();
		expPc.delete();
	endtask

	task automatic flagError(input string msg);
		$display("Error at time %0t: %s", $time, msg);
		errorCount++;
	endtask

	task automatic compareValue(input string name, input logic [`WORD_W-1:0] expected,
			input logic [`WORD_W-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("Fail at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Oldest expectation against the current report
	task automatic compareReport();
		logic write;
		logic [2:0] dst;
		logic [`WORD_W-1:0] data, nextPc;
		write = expWrite.pop_front();
		dst = expReg.pop_front();
		data = expData.pop_front();
		nextPc = expPc.pop_front();
		compareValue("wbWrite", {{(`WORD_W-1){1'b0}}, write}, {{(`WORD_W-1){1'b0}}, wbWrite});
		// Register and data only mean something on a write
		if (write) begin
			compareValue("wbReg", {{(`WORD_W-3){1'b0}}, dst}, {{(`WORD_W-3){1'b0}}, wbReg});
			compareValue("wbData", data, wbData);
		end
		compareValue("pcNext", nextPc, pcNext);
	endtask

	// Quiet state right after reset
	task automatic checkIdle();
		compareValue("wbValid", '0, {{(`WORD_W-1){1'b0}}, wbValid});
		compareValue("wbWrite", '0, {{(`WORD_W-1){1'b0}}, wbWrite});
		compareValue("pcNext", '0, pcNext);
	endtask

	task automatic reportTest(input int num, input string name);
		$display("Test %0d %s finished: %0d checks, %0d errors",
			num, name, checkCount - lastChecks, errorCount - lastErrors);
		lastChecks = checkCount;
		lastErrors = errorCount;
	endtask

	// Outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			if (expPc.size() == 0) begin
				flagError("wbValid was set with no instruction issued");
			end else begin
				compareReport();
			end
		end
	end

endmodule

`default_nettype wire

/* test/tbCore.sv */
//############################
// Execute slice testbench top
// Seeded random stream against a reference model
//############################
`timescale 1ns/1ps
`default_nettype none
`include "isa_params.svh"

module tbCore;

	// Watchdog budget, 20 cycles per instruction plus reset
	localparam int RESET_CYCLES = 16;
	localparam int TOTAL_INSTR = 1258;
	localparam int CLK_PERIOD = 20;

	logic clk, rstN;
	logic instrValid;
	logic [`WORD_W-1:0] instr, pc;
	logic wbValid, wbWrite;
	logic [2:0] wbReg;
	logic [`WORD_W-1:0] wbData, pcNext;

	// Reference register file
	logic [`WORD_W-1:0] modelRegs [`NUM_REGS];
	// Last destination, reused as a source for back-to-back reads
	logic [2:0] lastDest;
	integer seed;

	tbClock clockGen (.clk(clk), .rstN(rstN));

	cpuCore i_cpuCore (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
		.wbValid(wbValid), .wbWrite(wbWrite), .wbReg(wbReg),
		.wbData(wbData), .pcNext(pcNext)
	);

	tbChecker wbCheck (
		.clk(clk), .rstN(rstN), .wbValid(wbValid), .wbWrite(wbWrite),
		.wbReg(wbReg), .wbData(wbData), .pcNext(pcNext)
	);

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	// Any even address
	function automatic logic [`WORD_W-1:0] randomPc();
		logic [31:0] r;
		r = randWord();
		return {r[15:1], 1'b0};
	endfunction

	// Opcode table: ALU, four immediates, LBI, four branches, four jumps, NOP
	function automatic logic [4:0] opFromIndex(input logic [3:0] k);
		case (k)
			4'd1: return `OP_ADDI;
			4'd2: return `OP_SUBI;
			4'd3: return `OP_XORI;
			4'd4: return `OP_ANDNI;
			4'd5: return `OP_LBI;
			4'd6: return `OP_BEQZ;
			4'd7: return `OP_BNEZ;
			4'd8: return `OP_BLTZ;
			4'd9: return `OP_BGEZ;
			4'd10: return `OP_J;
			4'd11: return `OP_JAL;
			4'd12: return `OP_JR;
			4'd13: return `OP_JALR;
			4'd14: return `OP_NOP;
			default: return `OP_ALUR;
		endcase
	endfunction

	// Reference behavior of one instruction, then queue the expected report
	task automatic modelInstr(input logic [`WORD_W-1:0] word, input logic [`WORD_W-1:0] pcVal);
		logic [4:0] opcode;
		logic [2:0] dst;
		logic [`WORD_W-1:0] a, b, se5, ze5, se8, se11, pc2, result, nextPc;
		logic doWrite;
		opcode = word[15:11];
		a = modelRegs[word[10:8]];
		b = modelRegs[word[7:5]];
		se5 = {{11{word[4]}}, word[4:0]};
		ze5 = {11'b0, word[4:0]};
		se8 = {{8{word[7]}}, word[7:0]};
		se11 = {{5{word[10]}}, word[10:0]};
		pc2 = pcVal + 16'd2;
		doWrite = 1'b0;
		dst = 3'd0;
		result = '0;
		nextPc = pc2;
		case (opcode)
			`OP_ALUR: begin
				doWrite = 1'b1;
				dst = word[4:2];
				case (word[1:0])
					`FN_ADD: result = a + b;
					// rt minus rs
					`FN_SUB: result = b - a;
					`FN_XOR: result = a ^ b;
					default: result = a & ~b;
				endcase
			end
			`OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI: begin
				doWrite = 1'b1;
				dst = word[7:5];
				case (opcode)
					`OP_ADDI: result = a + se5;
					`OP_SUBI: result = se5 - a;
					`OP_XORI: result = a ^ ze5;
					default: result = a & ~ze5;
				endcase
			end
			`OP_LBI: begin
				doWrite = 1'b1;
				dst = word[10:8];
				result = se8;
			end
			`OP_BEQZ: nextPc = (a == '0) ? pc2 + se8 : pc2;
			`OP_BNEZ: nextPc = (a != '0) ? pc2 + se8 : pc2;
			`OP_BLTZ: nextPc = a[`WORD_W-1] ? pc2 + se8 : pc2;
			`OP_BGEZ: nextPc = a[`WORD_W-1] ? pc2 : pc2 + se8;
			`OP_J, `OP_JAL: nextPc = pc2 + se11;
			`OP_JR, `OP_JALR: nextPc = a + se8;
			default: nextPc = pc2;
		endcase
		// Links save the return address in r7
		if (opcode == `OP_JAL || opcode == `OP_JALR) begin
			doWrite = 1'b1;
			dst = `LINK_REG;
			result = pc2;
		end
		if (doWrite) begin
			modelRegs[dst] = result;
		end
		lastDest = dst;
		wbCheck.pushExpected(doWrite, dst, result, nextPc);
	endtask

	task automatic issueInstr(input logic [`WORD_W-1:0] word, input logic [`WORD_W-1:0] pcVal);
		@(posedge clk);
		#2;
		instr = word;
		pc = pcVal;
		instrValid = 1'b1;
		modelInstr(word, pcVal);
	endtask

	// Garbage on the bus while nothing is issued
	task automatic idleCycle();
		logic [31:0] r;
		@(posedge clk);
		#2;
		r = randWord();
		instrValid = 1'b0;
		instr = r[15:0];
		pc = r[31:16];
	endtask

	// Let the last report drain, flag any that never came
	task automatic finishTest(input int num, input string name);
		int waited;
		waited = 0;
		idleCycle();
		while (wbCheck.pending() != 0 && waited < 8) begin
			@(posedge clk);
			waited++;
		end
		if (wbCheck.pending() != 0) begin
			wbCheck.flagError("an issued instruction was never reported on wbValid");
			wbCheck.clearPending();
		end
		wbCheck.reportTest(num, name);
	endtask

	task automatic testResetLbi();
		logic [31:0] r;
		int i;
		repeat (3) idleCycle();
		@(negedge clk);
		wbCheck.checkIdle();
		for (i = 0; i < `NUM_REGS; i++) begin
			r = randWord();
			issueInstr({`OP_LBI, i[2:0], r[7:0]}, randomPc());
		end
		finishTest(1, "reset and LBI");
	endtask

	// group: 0 register ALU, 1 immediates, 2 branches, 3 jumps, 4 mixed with gaps
	task automatic runGroup(input int num, input string name, input int count, input int group);
		logic [31:0] r, s;
		logic [4:0] op;
		logic [2:0] rs, rt;
		int i;
		for (i = 0; i < count; i++) begin
			r = randWord();
			s = randWord();
			rs = s[0] ? lastDest : r[10:8];
			rt = s[1] ? lastDest : r[7:5];
			case (group)
				0: op = opFromIndex(4'd0);
				1: op = opFromIndex({2'b00, r[12:11]} + 4'd1);
				2: op = opFromIndex({2'b00, r[12:11]} + 4'd6);
				3: op = opFromIndex({2'b00, r[12:11]} + 4'd10);
				default: op = opFromIndex(r[14:11]);
			endcase
			// Load the tested register first, zero a quarter of the time
			if (group == 2 && s[2]) begin
				issueInstr({`OP_LBI, rs, (s[4:3] == 2'b00) ? 8'h00 : s[15:8]}, randomPc());
			end
			if (group == 4 && s[6:5] == 2'b00) begin
				repeat (s[8:7] + 1) idleCycle();
			end
			issueInstr({op, rs, rt, r[4:0]}, randomPc());
		end
		finishTest(num, name);
	endtask

	initial begin
		seed = 82491;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		lastDest = 3'd0;
		for (int k = 0; k < `NUM_REGS; k++) begin
			modelRegs[k] = '0;
		end
		wait (rstN === 1'b1);
		testResetLbi();
		runGroup(2, "register ALU", 200, 0);
		runGroup(3, "immediate ALU", 200, 1);
		runGroup(4, "branches", 150, 2);
		runGroup(5, "jumps", 150, 3);
		runGroup(6, "mixed stream", 400, 4);
		$display("Summary: %0d checks, %0d errors", wbCheck.checks(), wbCheck.errors());
		if (wbCheck.errors() == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((RESET_CYCLES + 20 * TOTAL_INSTR) * CLK_PERIOD);
		$display("Watchdog expired: the run hung before all tests finished");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
design/isaPkg.sv
design/instrDecode.sv
design/executeInstruction.sv
design/resultWriteback.sv
design/cpuCore.sv
test/tbClock.sv
test/tbChecker.sv
test/tbCore.sv

/* run.sh */
#!/bin/sh
# Build the execute slice testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tbCore -o simTbCore

./obj_dir/simTbCore | tee sim.log

if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then
	echo "Simulation FAILED, see sim.log"
	exit 1
fi
echo "Simulation passed"
